/* hdl/audio_tone_config.svh */
/*
  Build-time constants for the I2S tone generator.
  Included by the package, the RTL blocks and the testbench.
*/
`ifndef AUDIO_TONE_CONFIG_SVH
`define AUDIO_TONE_CONFIG_SVH

//////////////////////////////
// clocking

// mclk divider width, sclk is mclk / 4
`define AUD_SCLK_DIV_BITS 2

//////////////////////////////
// frame format

// bit slots in one channel word
`define AUD_BITS_PER_WORD 32
// active sample bits at the start of each word
`define AUD_SAMPLE_BITS 16

//////////////////////////////
// tone

// half period in channel words at normal pitch
`define AUD_HALF_PERIOD_BASE 109
// one octave lower
`define AUD_HALF_PERIOD_LOW 218
// high level code, 1/16 of full scale
`define AUD_TONE_AMPLITUDE 16'h0800

`endif

/* hdl/audio_tone_pkg.sv */
/*
  Shared types of the I2S tone generator.
  Sample, slot index, oscillator counter and the packed I2S pin bus.
*/
`default_nettype none

`include "audio_tone_config.svh"

package audio_tone_pkg;

  //////////////////////////////
  // payload and counters

  // one channel sample, two's complement code
  typedef logic [`AUD_SAMPLE_BITS-1:0] audio_sample_t;

  // slot position inside a 32 bit word
  typedef logic [$clog2(`AUD_BITS_PER_WORD)-1:0] bit_index_t;

  // word counter of the square oscillator
  // wide enough for the low octave half period
  typedef logic [7:0] half_period_t;

  //////////////////////////////
  // pins

  // i2s outputs as one group
  // sclk is the bit clock, lrck the word select
  typedef struct packed {
    logic sclk;
    logic lrck;
    logic dac;
  } i2s_bus_t;

endpackage

`default_nettype wire

/* hdl/i2s_clock_gen.sv */
/*
  Bit clock generator.
  Divides audgen_mclk by four into the sclk level and a one cycle
  strobe that marks the mclk edge on which sclk falls.
*/
`timescale 1ns/1ps
`default_nettype none

`include "audio_tone_config.svh"

module i2s_clock_gen (
  input  wire  audgen_mclk,
  input  wire  reset_n,
  output logic sclk,
  output logic sclk_fall
);

  //////////////////////////////
  // divider

  // free running mclk counter
  logic [`AUD_SCLK_DIV_BITS-1:0] div_cnt;

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      div_cnt <= '0;
    end else begin
      // wraps on its own
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // outputs

  // upper bit gives 2 high and 2 low mclk cycles
  assign sclk = div_cnt[`AUD_SCLK_DIV_BITS-1];

  // all ones now, zero on the next edge
  // so sclk drops on the edge that ends this cycle
  // downstream logic updates on that same edge
  assign sclk_fall = &div_cnt;

endmodule

`default_nettype wire

/* hdl/i2s_frame_timer.sv */
/*
  I2S frame timer.
  Counts the bit slots of each channel word on sclk falls, marks the
  word boundary and drives lrck one slot ahead of the MSB.
*/
`timescale 1ns/1ps
`default_nettype none

`include "audio_tone_config.svh"

module i2s_frame_timer (
  input  wire                       audgen_mclk,
  input  wire                       reset_n,
  input  wire                       sclk_fall,
  output audio_tone_pkg::bit_index_t bit_index,
  output logic                      word_start,
  output logic                      lrck
);

  import audio_tone_pkg::*;

  // last slot of a word
  localparam bit_index_t last_slot = bit_index_t'(`AUD_BITS_PER_WORD - 1);
  // slot after which lrck switches
  localparam bit_index_t lrck_slot = bit_index_t'(`AUD_BITS_PER_WORD - 2);

  //////////////////////////////
  // slot counter

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      bit_index <= '0;
    end else if (sclk_fall) begin
      // 32 slots, natural wrap
      bit_index <= bit_index + 1'b1;
    end
  end

  // high in the cycle whose edge takes bit_index to 0
  // slot 0 of the new word starts on that edge
  assign word_start = sclk_fall && (bit_index == last_slot);

  //////////////////////////////
  // word select

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      lrck <= 1'b0;
    end else if (sclk_fall && (bit_index == lrck_slot)) begin
      // switch as slot 31 begins
      // one bit before the next MSB, i2s style
      lrck <= ~lrck;
    end
  end

endmodule

`default_nettype wire

/* hdl/square_tone_osc.sv */
/*
  Square wave tone oscillator.
  Counts channel words and flips the output level every half period.
  octave_down doubles the half period, one octave lower.
*/
`timescale 1ns/1ps
`default_nettype none

`include "audio_tone_config.svh"

module square_tone_osc (
  input  wire                          audgen_mclk,
  input  wire                          reset_n,
  input  wire                          word_start,
  input  wire                          octave_down,
  output audio_tone_pkg::audio_sample_t sample
);

  import audio_tone_pkg::*;

  localparam half_period_t half_base = half_period_t'(`AUD_HALF_PERIOD_BASE);
  localparam half_period_t half_low  = half_period_t'(`AUD_HALF_PERIOD_LOW);

  // words counted in the current level
  half_period_t word_cnt;
  // selected run length
  half_period_t half_period;
  // square wave level, high gives the amplitude code
  logic         level;

  //////////////////////////////
  // pitch select

  // only looked at on word_start
  // so a change shortens or stretches the run in progress
  assign half_period = octave_down ? half_low : half_base;

  //////////////////////////////
  // oscillator

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      word_cnt <= half_period_t'(1);
      level    <= 1'b0;
    end else if (word_start) begin
      if (word_cnt < half_period) begin
        word_cnt <= word_cnt + 1'b1;
      end else begin
        // run complete, restart count at 1
        // >= also covers a drop from the low to the base pitch
        word_cnt <= half_period_t'(1);
        level    <= ~level;
      end
    end
  end

  //////////////////////////////
  // sample

  // not centered, DC offset of half the amplitude
  // valid one mclk cycle after word_start
  assign sample = level ? audio_sample_t'(`AUD_TONE_AMPLITUDE) : '0;

endmodule

`default_nettype wire

/* hdl/i2s_serializer.sv */
/*
  I2S data serializer.
  Loads the sample as a word starts and shifts it out MSB first on
  sclk falls, followed by zero bits up to the end of the word.
*/
`timescale 1ns/1ps
`default_nettype none

`include "audio_tone_config.svh"

module i2s_serializer (
  input  wire                           audgen_mclk,
  input  wire                           reset_n,
  input  wire                           sclk_fall,
  input  wire                           word_start,
  input  wire audio_tone_pkg::bit_index_t    bit_index,
  input  wire audio_tone_pkg::audio_sample_t sample,
  output logic                          dac
);

  import audio_tone_pkg::*;

  localparam int msb = `AUD_SAMPLE_BITS - 1;

  // bits still to send, MSB on top
  audio_sample_t shift_reg;
  // slot that starts on the coming sclk fall
  bit_index_t    next_slot;

  assign next_slot = bit_index + 1'b1;

  //////////////////////////////
  // shifter

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      shift_reg <= '0;
      dac       <= 1'b0;
    end else if (sclk_fall) begin
      if (word_start) begin
        // slot 0 gets the MSB straight from the sample
        dac       <= sample[msb];
        shift_reg <= {sample[msb-1:0], 1'b0};
      end else if (next_slot < `AUD_SAMPLE_BITS) begin
        // active slots 1 to 15
        dac       <= shift_reg[msb];
        shift_reg <= {shift_reg[msb-1:0], 1'b0};
      end else begin
        // dummy slots 16 to 31
        dac <= 1'b0;
      end
    end
  end

  // receiver samples dac on the sclk rise
  // two mclk cycles after each change

endmodule

`default_nettype wire

/* hdl/audio_tone_top.sv */
/*
  Top level of the I2S tone generator.
  Runs on the 12.288 MHz audgen_mclk and drives a 48 kHz stereo stream
  with a square wave tone on both channels.
*/
`timescale 1ns/1ps
`default_nettype none

module audio_tone_top (
  input  wire                      audgen_mclk,
  input  wire                      reset_n,
  input  wire                      octave_down,
  output audio_tone_pkg::i2s_bus_t i2s
);

  import audio_tone_pkg::*;

  logic          sclk;
  logic          sclk_fall;
  bit_index_t    bit_index;
  logic          word_start;
  logic          lrck;
  audio_sample_t sample;
  logic          dac;

  //////////////////////////////
  // timing

  // sclk = mclk / 4
  i2s_clock_gen i_clock_gen (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .sclk        (sclk),
    .sclk_fall   (sclk_fall)
  );

  // 32 slots per channel, 64 per frame
  i2s_frame_timer i_frame_timer (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .sclk_fall   (sclk_fall),
    .bit_index   (bit_index),
    .word_start  (word_start),
    .lrck        (lrck)
  );

  //////////////////////////////
  // data path

  // new sample one cycle after word_start
  // so it goes out in the following word
  square_tone_osc i_tone_osc (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .word_start  (word_start),
    .octave_down (octave_down),
    .sample      (sample)
  );

  i2s_serializer i_serializer (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .sclk_fall   (sclk_fall),
    .word_start  (word_start),
    .bit_index   (bit_index),
    .sample      (sample),
    .dac         (dac)
  );

  // pin bus
  assign i2s = '{sclk: sclk, lrck: lrck, dac: dac};

endmodule

`default_nettype wire

/* tb/audio_tone_tb_checks.svh */
/*
  I2S decoding and run tracking for the tone generator testbench.
  Included in the testbench module. sample_bus runs on each mclk fall,
  next_run is called from the stimulus loop.
*/
`ifndef AUDIO_TONE_TB_CHECKS_SVH
`define AUDIO_TONE_TB_CHECKS_SVH

  // bus history
  logic        sclk_prev = 1'b0;
  logic        lrck_prev = 1'b0;
  bit          sclk_seen = 1'b0;
  bit          lrck_seen = 1'b0;
  int          level_len = 0;
  int          rise_cnt  = 0;
  // slot 0 ends up in bit 31
  logic [31:0] word_sr   = '0;
  logic [31:0] word_q [$];

  // current run of equal words
  logic [31:0] run_word  = '0;
  int          run_count = 0;
  bit          run_open  = 1'b0;

  task automatic check_word(input logic [31:0] w);
    // slots 16 to 31 are dummy zeros
    assert (w[15:0] == 16'h0000) else
      report_mismatch("word_dummy_bits", 32'h0, 32'(w[15:0]));
    assert ((w == amp_word) || (w == 32'h0)) else
      stop_on_error($sformatf("ERR word_sample: expected 0x%0h or 0x0, actual 0x%0h",
                              amp_word, w));
  endtask

  task automatic sample_bus();
    logic  sclk_now;
    logic  lrck_now;
    logic  dac_now;
    string level_name;
    sclk_now = i2s.sclk;
    lrck_now = i2s.lrck;
    dac_now  = i2s.dac;

    // 2 mclk high, 2 low
    if (sclk_now != sclk_prev) begin
      if (sclk_prev) begin
        level_name = "sclk_high";
      end else begin
        level_name = "sclk_low";
      end
      if (sclk_seen) begin
        assert (level_len == 2) else
          report_mismatch(level_name, 32'd2, level_len);
      end
      sclk_seen = 1'b1;
      level_len = 1;
    end else begin
      level_len++;
    end

    // 32 bit clocks between lrck toggles
    if (lrck_now != lrck_prev) begin
      if (lrck_seen) begin
        assert (rise_cnt == 32) else
          report_mismatch("lrck_period", 32'd32, rise_cnt);
      end
      lrck_seen = 1'b1;
      rise_cnt  = 0;
    end

    // receiver samples dac on sclk rise
    if (sclk_now && !sclk_prev) begin
      word_sr = {word_sr[30:0], dac_now};
      rise_cnt++;
      // first rise after the toggle is slot 31, word complete
      if (lrck_seen && rise_cnt == 1) begin
        check_word(word_sr);
        word_q.push_back(word_sr);
      end
    end

    sclk_prev = sclk_now;
    lrck_prev = lrck_now;
  endtask

  task automatic fetch_word(output logic [31:0] w);
    while (word_q.size() == 0) begin
      @(negedge audgen_mclk);
    end
    w = word_q.pop_front();
  endtask

  // returns the run that ends at the next change of word value
  task automatic next_run(output logic [31:0] value, output int len);
    logic [31:0] w;
    bit          done;
    done = 1'b0;
    while (!done) begin
      fetch_word(w);
      if (!run_open) begin
        run_word  = w;
        run_count = 1;
        run_open  = 1'b1;
      end else if (w == run_word) begin
        run_count++;
      end else begin
        value     = run_word;
        len       = run_count;
        run_word  = w;
        run_count = 1;
        done      = 1'b1;
      end
    end
  endtask

`endif

/* tb/audio_tone_tb.sv */
/*
  Testbench of the I2S tone generator.
  Applies a table of pitch settings to the DUT, decodes the I2S stream
  and checks frame timing, word format and square wave run lengths.
*/
`timescale 1ns/1ps
`default_nettype none

`include "audio_tone_config.svh"

module audio_tone_tb;

  import audio_tone_pkg::*;

  // numeric part of one stimulus row
  typedef struct packed {
    logic        octave_down;
    logic [15:0] runs;
    logic [15:0] half_period;
  } stim_row_t;

  localparam int num_rows = 3;
  // one channel word lasts 32 bit clocks of 4 mclk cycles of 10 ns
  localparam longint word_ns = longint'(`AUD_BITS_PER_WORD) * 4 * 10;
  // decoded high level word with zero dummy bits below the sample
  localparam logic [31:0] amp_word = {`AUD_TONE_AMPLITUDE, 16'h0000};

  //////////////////////////////
  // stimulus table

  // octave_down, runs to check, expected half period in words
  stim_row_t stim_tab [num_rows] = '{
    {1'b0, 16'd3, 16'd109},
    {1'b1, 16'd3, 16'd218},
    {1'b0, 16'd2, 16'd109}
  };
  string     row_name [num_rows] = '{"base", "low", "base_again"};

  logic      audgen_mclk;
  logic      reset_n;
  logic      octave_down;
  i2s_bus_t  i2s;
  bit        monitor_en;

  audio_tone_top i_dut (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .octave_down (octave_down),
    .i2s         (i2s)
  );

  // 100 MHz stand-in for the 12.288 MHz mclk
  always #5 audgen_mclk = ~audgen_mclk;

  //////////////////////////////
  // error handling

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_on_error($sformatf("ERR %s: expected %0d (0x%0h), actual %0d (0x%0h)",
                            name, expected, expected, actual, actual));
  endtask

  task automatic check_idle(input string name);
    assert (i2s == 3'b000) else
      report_mismatch(name, 32'h0, 32'(i2s));
  endtask

  `include "audio_tone_tb_checks.svh"

  // bus monitor samples once the outputs have settled
  always @(negedge audgen_mclk) begin
    if (monitor_en) begin
      sample_bus();
    end
  end

  //////////////////////////////
  // watchdog

  function automatic longint timeout_ns();
    longint words;
    int     i;
    words = 0;
    for (i = 0; i < num_rows; i++) begin
      // two discarded runs per row on top of the checked ones
      words += longint'(stim_tab[i].runs + 16'd2) * longint'(stim_tab[i].half_period);
    end
    // margin for reset and decoder lag
    return (words + longint'(2 * `AUD_HALF_PERIOD_LOW)) * word_ns + 1000;
  endfunction

  initial begin : watchdog
    longint limit;
    limit = timeout_ns();
    #(limit);
    stop_on_error($sformatf("timeout: the stimulus did not finish within %0d ns", limit));
  end

  //////////////////////////////
  // stimulus

  initial begin : stimulus
    int          row;
    int          run;
    int          exp_len;
    int          run_len;
    logic [31:0] run_val;

    audgen_mclk = 1'b0;
    reset_n     = 1'b0;
    octave_down = 1'b0;
    monitor_en  = 1'b0;
    run_val     = '0;

    // outputs quiet while in reset
    repeat (5) begin
      @(negedge audgen_mclk);
      check_idle("reset_hold");
    end
    reset_n = 1'b1;
    @(negedge audgen_mclk);
    check_idle("after_reset");
    @(posedge audgen_mclk);
    monitor_en = 1'b1;

    for (row = 0; row < num_rows; row++) begin
      @(negedge audgen_mclk);
      octave_down = stim_tab[row].octave_down;
      exp_len = int'(stim_tab[row].half_period);
      // run in progress and the one behind it
      repeat (2) begin
        next_run(run_val, run_len);
      end
      for (run = 0; run < int'(stim_tab[row].runs); run++) begin
        next_run(run_val, run_len);
        assert (run_len == exp_len) else
          report_mismatch(row_name[row], exp_len, run_len);
      end
      $display("row %s: %0d runs of %0d words", row_name[row], stim_tab[row].runs, exp_len);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
+incdir+tb
hdl/audio_tone_pkg.sv
hdl/i2s_clock_gen.sv
hdl/i2s_frame_timer.sv
hdl/square_tone_osc.sv
hdl/i2s_serializer.sv
hdl/audio_tone_top.sv
tb/audio_tone_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the tone generator testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module audio_tone_tb \
  -f filelist.f \
  -o audio_tone_sim \
  && ./obj_dir/audio_tone_sim | tee /dev/stderr | grep -q "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
